// File: src/lc3_pkg.sv
/*
 * shared definitions for the LC-3 core
 * word and register index types, opcodes, FSM states
 * datapath selector encodings, instruction field positions, reset values
 */
package lc3_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    localparam int WORD_W   = 16;
    localparam int NUM_REGS = 8;
    localparam int IMM5_W   = 5;
    localparam int OFF6_W   = 6;
    localparam int OFF9_W   = 9;
    localparam int OFF11_W  = 11;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    ////////////////////////////////////////////////////////////
    // instruction field positions, lsb of each field
    localparam int OPC_LSB = 12;
    localparam int DR_LSB  = 9;
    localparam int SR1_LSB = 6;
    localparam int SR2_LSB = 0;
    // nzp mask of BR shares bits with dr
    localparam int NZP_LSB = 9;
    // immediate form of ADD/AND
    localparam int IMM_BIT = 5;
    // 1 for JSR, 0 for JSRR
    localparam int JSR_BIT = 11;

    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_JSR = 4'b0100,
        OP_AND = 4'b0101,
        OP_LDR = 4'b0110,
        OP_STR = 4'b0111,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // control FSM and datapath selectors
    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXEC,
        S_MEM_WAIT,
        S_LOAD_WB,
        S_STORE
    } state_t;

    // pass forwards the address adder, used by LEA
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASS} alu_op_t;
    typedef enum logic [1:0] {ADDR_PC, ADDR_BASE} addr_sel_t;
    typedef enum logic [1:0] {OFF_ZERO, OFF_6, OFF_9, OFF_11} off_sel_t;
    // register write source
    typedef enum logic {WB_ALU, WB_MEM} wb_sel_t;

    // reset values
    localparam word_t      RESET_PC = 16'h0000;
    // n z p order, z set out of reset
    localparam logic [2:0] RESET_CC = 3'b010;
    localparam reg_idx_t   LINK_REG = 3'd7;

endpackage

// File: src/lc3_ctrl_if.sv
/*
 * control bus between the FSM and the datapath
 * strobes and selectors one way, decoded instruction flags back
 */
`timescale 1ns/100ps

interface lc3_ctrl_if;
    import lc3_pkg::*;

    // strobes from the FSM
    logic      load_ir;
    logic      pc_inc;
    logic      pc_load;
    logic      mar_load;
    logic      mdr_load;
    logic      write_enable;
    logic      reg_write;
    wb_sel_t   wb_sel;
    alu_op_t   alu_op;
    addr_sel_t addr_sel;
    off_sel_t  off_sel;
    // JSR/JSRR return address write
    logic      link;

    // fields from the instruction register
    opcode_t   opcode;
    logic      imm_sw;
    logic      jsr_sw;
    logic      branch_taken;

    modport control (
        output load_ir, pc_inc, pc_load, mar_load, mdr_load, write_enable,
        output reg_write, wb_sel, alu_op, addr_sel, off_sel, link,
        input  opcode, imm_sw, jsr_sw, branch_taken
    );

    modport datapath (
        input  load_ir, pc_inc, pc_load, mar_load, mdr_load,
        input  reg_write, wb_sel, alu_op, addr_sel, off_sel, link,
        output opcode, imm_sw, jsr_sw, branch_taken
    );
endinterface

// File: src/lc3_reg_if.sv
/*
 * register file ports
 * two reads, one write, condition codes and their load strobe
 */
`timescale 1ns/100ps

interface lc3_reg_if;
    import lc3_pkg::*;

    reg_idx_t sr1;
    reg_idx_t sr2;
    reg_idx_t dr;
    word_t    wdata;
    logic     reg_write;
    logic     flags_load;
    word_t    rd1;
    word_t    rd2;
    logic     cc_n;
    logic     cc_z;
    logic     cc_p;

    modport datapath (
        output sr1, sr2, dr, wdata, reg_write,
        input  rd1, rd2, cc_n, cc_z, cc_p
    );
    modport regfile (
        input  sr1, sr2, dr, wdata, reg_write, flags_load,
        output rd1, rd2, cc_n, cc_z, cc_p
    );
    modport control (output flags_load);
endinterface

// File: src/lc3_regfile.sv
/*
 * general register file R0..R7
 * two combinational reads, one clocked write, n/z/p flags
 */
`timescale 1ns/100ps

module lc3_regfile (
    input logic         clk,
    input logic         arst_n,
    lc3_reg_if.regfile  regs
);
    import lc3_pkg::*;

    word_t      rf [NUM_REGS];
    // n z p
    logic [2:0] cc;

    // read ports, no bypass of a same-cycle write
    assign regs.rd1 = rf[regs.sr1];
    assign regs.rd2 = rf[regs.sr2];

    assign regs.cc_n = cc[2];
    assign regs.cc_z = cc[1];
    assign regs.cc_p = cc[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rf <= '{default: '0};
        end else if (regs.reg_write) begin
            rf[regs.dr] <= regs.wdata;
        end
    end

    // flags follow the value being written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= RESET_CC;
        end else if (regs.flags_load) begin
            cc[2] <= regs.wdata[WORD_W-1];
            cc[1] <= (regs.wdata == '0);
            // positive means sign clear and nonzero
            cc[0] <= !regs.wdata[WORD_W-1] && (regs.wdata != '0);
        end
    end

endmodule

// File: src/lc3_control.sv
/*
 * multicycle control FSM
 * fetch, wait, decode, then one to three execute states
 * all strobes are decoded from the state and the opcode
 */
`timescale 1ns/100ps

module lc3_control (
    input logic         clk,
    input logic         arst_n,
    lc3_ctrl_if.control ctrl,
    lc3_reg_if.control  regs
);
    import lc3_pkg::*;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        // idle defaults, nothing written
        ctrl.load_ir      = 1'b0;
        ctrl.pc_inc       = 1'b0;
        ctrl.pc_load      = 1'b0;
        ctrl.mar_load     = 1'b0;
        ctrl.mdr_load     = 1'b0;
        ctrl.write_enable = 1'b0;
        ctrl.reg_write    = 1'b0;
        ctrl.wb_sel       = WB_ALU;
        ctrl.alu_op       = ALU_PASS;
        ctrl.addr_sel     = ADDR_PC;
        ctrl.off_sel      = OFF_ZERO;
        ctrl.link         = 1'b0;
        regs.flags_load   = 1'b0;
        state_nxt         = state;

        case (state)
            ////////////////////////////////////////////////////////////
            // instruction fetch
            S_FETCH: begin
                // adder gives pc + 0 into MAR
                ctrl.mar_load = 1'b1;
                ctrl.pc_inc   = 1'b1;
                state_nxt     = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                // memory samples MAR at the end of this cycle
                state_nxt = S_DECODE;
            end
            S_DECODE: begin
                ctrl.load_ir = 1'b1;
                state_nxt    = S_EXEC;
            end

            ////////////////////////////////////////////////////////////
            // execute, pc already points past the instruction
            S_EXEC: begin
                state_nxt = S_FETCH;
                case (ctrl.opcode)
                    OP_ADD, OP_AND, OP_NOT: begin
                        ctrl.alu_op = (ctrl.opcode == OP_ADD) ? ALU_ADD :
                                      (ctrl.opcode == OP_AND) ? ALU_AND : ALU_NOT;
                        ctrl.reg_write  = 1'b1;
                        regs.flags_load = 1'b1;
                    end
                    OP_LEA: begin
                        // address passes through the alu
                        ctrl.off_sel    = OFF_9;
                        ctrl.reg_write  = 1'b1;
                        regs.flags_load = 1'b1;
                    end
                    OP_BR: begin
                        ctrl.off_sel = OFF_9;
                        ctrl.pc_load = ctrl.branch_taken;
                    end
                    OP_JMP: begin
                        // RET is JMP R7
                        ctrl.addr_sel = ADDR_BASE;
                        ctrl.pc_load  = 1'b1;
                    end
                    OP_JSR: begin
                        // JSR is pc relative, JSRR jumps to base
                        if (ctrl.jsr_sw) begin
                            ctrl.off_sel = OFF_11;
                        end else begin
                            ctrl.addr_sel = ADDR_BASE;
                        end
                        ctrl.link      = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.pc_load   = 1'b1;
                    end
                    OP_LD, OP_LDR: begin
                        if (ctrl.opcode == OP_LDR) begin
                            ctrl.addr_sel = ADDR_BASE;
                            ctrl.off_sel  = OFF_6;
                        end else begin
                            ctrl.off_sel = OFF_9;
                        end
                        ctrl.mar_load = 1'b1;
                        state_nxt     = S_MEM_WAIT;
                    end
                    OP_ST, OP_STR: begin
                        if (ctrl.opcode == OP_STR) begin
                            ctrl.addr_sel = ADDR_BASE;
                            ctrl.off_sel  = OFF_6;
                        end else begin
                            ctrl.off_sel = OFF_9;
                        end
                        // source register goes to the write data register
                        ctrl.mar_load = 1'b1;
                        ctrl.mdr_load = 1'b1;
                        state_nxt     = S_STORE;
                    end
                    default: begin
                        // unused opcodes act as no-ops
                        state_nxt = S_FETCH;
                    end
                endcase
            end

            ////////////////////////////////////////////////////////////
            // memory phases of loads and stores
            S_MEM_WAIT: begin
                state_nxt = S_LOAD_WB;
            end
            S_LOAD_WB: begin
                ctrl.wb_sel     = WB_MEM;
                ctrl.reg_write  = 1'b1;
                regs.flags_load = 1'b1;
                state_nxt       = S_FETCH;
            end
            S_STORE: begin
                // single cycle write pulse
                ctrl.write_enable = 1'b1;
                state_nxt         = S_FETCH;
            end
            default: begin
                state_nxt = S_FETCH;
            end
        endcase
    end

endmodule

// File: src/lc3_datapath.sv
/*
 * LC-3 datapath
 * PC, IR, MAR, write data register, ALU and address adder
 * field split, sign extension, branch condition
 */
`timescale 1ns/100ps

module lc3_datapath (
    input  logic                clk,
    input  logic                arst_n,
    lc3_ctrl_if.datapath        ctrl,
    lc3_reg_if.datapath         regs,
    input  lc3_pkg::word_t      read_data,
    output lc3_pkg::word_t      addr,
    output lc3_pkg::word_t      write_data
);
    import lc3_pkg::*;

    word_t      pc;
    word_t      ir;
    word_t      mar;
    word_t      mdr;
    word_t      imm5_sx;
    word_t      off6_sx;
    word_t      off9_sx;
    word_t      off11_sx;
    word_t      addr_base;
    word_t      addr_off;
    word_t      addr_sum;
    word_t      alu_b;
    word_t      alu_y;
    logic [2:0] nzp;
    logic       is_store;

    ////////////////////////////////////////////////////////////
    // instruction fields
    assign ctrl.opcode = opcode_t'(ir[OPC_LSB +: $bits(opcode_t)]);
    assign ctrl.imm_sw = ir[IMM_BIT];
    assign ctrl.jsr_sw = ir[JSR_BIT];
    assign nzp         = ir[NZP_LSB +: 3];
    assign is_store    = (ctrl.opcode == OP_ST) || (ctrl.opcode == OP_STR);

    // sign extension
    assign imm5_sx  = {{(WORD_W-IMM5_W){ir[IMM5_W-1]}}, ir[IMM5_W-1:0]};
    assign off6_sx  = {{(WORD_W-OFF6_W){ir[OFF6_W-1]}}, ir[OFF6_W-1:0]};
    assign off9_sx  = {{(WORD_W-OFF9_W){ir[OFF9_W-1]}}, ir[OFF9_W-1:0]};
    assign off11_sx = {{(WORD_W-OFF11_W){ir[OFF11_W-1]}}, ir[OFF11_W-1:0]};

    // register addressing
    // stores read their source from the dr field on port 2
    assign regs.sr1 = ir[SR1_LSB +: $bits(reg_idx_t)];
    assign regs.sr2 = is_store ? ir[DR_LSB +: $bits(reg_idx_t)]
                               : ir[SR2_LSB +: $bits(reg_idx_t)];
    assign regs.dr  = ctrl.link ? LINK_REG : ir[DR_LSB +: $bits(reg_idx_t)];
    assign regs.reg_write = ctrl.reg_write;

    // any set mask bit matching the flags takes the branch
    assign ctrl.branch_taken = |(nzp & {regs.cc_n, regs.cc_z, regs.cc_p});

    ////////////////////////////////////////////////////////////
    // address adder, base plus offset
    assign addr_base = (ctrl.addr_sel == ADDR_BASE) ? regs.rd1 : pc;

    always_comb begin
        case (ctrl.off_sel)
            OFF_6:   addr_off = off6_sx;
            OFF_9:   addr_off = off9_sx;
            OFF_11:  addr_off = off11_sx;
            default: addr_off = '0;
        endcase
    end

    assign addr_sum = addr_base + addr_off;

    // alu, operand b is imm5 or sr2
    assign alu_b = ctrl.imm_sw ? imm5_sx : regs.rd2;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_y = regs.rd1 + alu_b;
            ALU_AND: alu_y = regs.rd1 & alu_b;
            ALU_NOT: alu_y = ~regs.rd1;
            default: alu_y = addr_sum;
        endcase
    end

    // writeback, link takes the pc before the jump
    always_comb begin
        if (ctrl.link) begin
            regs.wdata = pc;
        end else if (ctrl.wb_sel == WB_MEM) begin
            regs.wdata = read_data;
        end else begin
            regs.wdata = alu_y;
        end
    end

    ////////////////////////////////////////////////////////////
    // state registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= RESET_PC;
            mar <= RESET_PC;
        end else begin
            if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end else if (ctrl.pc_load) begin
                pc <= addr_sum;
            end
            if (ctrl.mar_load) begin
                mar <= addr_sum;
            end
        end
    end

    // instruction and store data
    always_ff @(posedge clk) begin
        if (ctrl.load_ir) begin
            ir <= read_data;
        end
        if (ctrl.mdr_load) begin
            mdr <= regs.rd2;
        end
    end

    assign addr       = mar;
    assign write_data = mdr;

endmodule

// File: src/lc3_core.sv
/*
 * LC-3 core top level
 * control FSM, datapath and register file on one memory port
 */
`timescale 1ns/100ps

module lc3_core (
    input  logic            clk,
    input  logic            arst_n,
    output lc3_pkg::word_t  addr,
    output logic            write_enable,
    output lc3_pkg::word_t  write_data,
    input  lc3_pkg::word_t  read_data
);

    // internal buses
    lc3_ctrl_if ctrl_bus ();
    lc3_reg_if  reg_bus ();

    lc3_control u_control (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl_bus.control),
        .regs   (reg_bus.control)
    );

    lc3_datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl_bus.datapath),
        .regs       (reg_bus.datapath),
        .read_data  (read_data),
        .addr       (addr),
        .write_data (write_data)
    );

    lc3_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .regs   (reg_bus.regfile)
    );

    // write strobe comes straight from the FSM
    assign write_enable = ctrl_bus.write_enable;

endmodule

// File: testbench/tb_lc3_core.sv
/*
 * testbench for the LC-3 core
 * clock, reset, synchronous memory model with a store log
 * small assembler helpers and directed tests per instruction group
 */
`timescale 1ns/100ps

module tb_lc3_core;
    import lc3_pkg::*;

    localparam int STORE_TIMEOUT = 2000;

    logic  clk       = 1'b0;
    logic  arst_n    = 1'b0;
    word_t read_data = '0;
    word_t addr;
    word_t write_data;
    logic  write_enable;

    // memory contents and the log of every write strobe
    word_t mem [word_t];
    word_t st_addr_q [$];
    word_t st_data_q [$];
    int    prog_addr;
    int    errors;

    lc3_core dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .addr         (addr),
        .write_enable (write_enable),
        .write_data   (write_data),
        .read_data    (read_data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // read data follows the address of the previous edge
    always @(posedge clk) begin
        if (mem.exists(addr)) begin
            read_data <= mem[addr];
        end else begin
            read_data <= '0;
        end
        if (write_enable) begin
            mem[addr] = write_data;
            st_addr_q.push_back(addr);
            st_data_q.push_back(write_data);
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoders
    function automatic word_t alu_reg(input opcode_t op, input int dr, input int sr1,
                                      input int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic word_t alu_imm(input opcode_t op, input int dr, input int sr1,
                                      input int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic word_t not_op(input int dr, input int sr);
        return {OP_NOT, 3'(dr), 3'(sr), 6'b111111};
    endfunction

    // r is the register field or the nzp mask for BR
    function automatic word_t pc_rel(input opcode_t op, input int r, input int off9);
        return {op, 3'(r), 9'(off9)};
    endfunction

    // LDR, STR, JMP and JSRR layout
    function automatic word_t base_off(input opcode_t op, input int r, input int base,
                                       input int off6);
        return {op, 3'(r), 3'(base), 6'(off6)};
    endfunction

    ////////////////////////////////////////////////////////////
    // program building and run control
    task automatic put(input word_t w);
        mem[16'(prog_addr)] = w;
        prog_addr++;
    endtask

    // offset counted from the address after the instruction
    task automatic put_pcrel(input opcode_t op, input int r, input int target);
        put(pc_rel(op, r, target - prog_addr - 1));
    endtask

    task automatic put_jsr(input int target);
        put({OP_JSR, 1'b1, 11'(target - prog_addr - 1)});
    endtask

    task automatic begin_program();
        @(posedge clk);
        arst_n <= 1'b0;
        mem.delete();
        st_addr_q.delete();
        st_data_q.delete();
        prog_addr = 0;
    endtask

    // BRnzp #-1 spins in place
    task automatic end_main();
        put(pc_rel(OP_BR, 7, -1));
    endtask

    task automatic run_program();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_stores(input int n, input string name);
        int cycles;
        cycles = 0;
        while (st_addr_q.size() < n && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (st_addr_q.size() < n) begin
            $display("timeout in %s test: saw %0d of %0d stores", name, st_addr_q.size(), n);
            errors++;
        end
        // a strobe longer than one cycle logs extra entries while the core spins
        repeat (12) @(negedge clk);
        if (st_addr_q.size() != n) begin
            $display("CHECK FAILED at %0t: %s test saw %0d stores, expected %0d", $time,
                     name, st_addr_q.size(), n);
            errors++;
        end
    endtask

    task automatic check_store(input int idx, input int exp_addr, input word_t exp_data,
                               input string msg);
        if (idx >= st_addr_q.size()) begin
            $display("store %0d never happened (%s)", idx, msg);
            errors++;
        end else if (st_addr_q[idx] !== 16'(exp_addr) || st_data_q[idx] !== exp_data) begin
            $display("CHECK FAILED at %0t: %s, got %h at %h, expected %h at %h", $time, msg,
                     st_data_q[idx], st_addr_q[idx], exp_data, 16'(exp_addr));
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic alu_ops();
        begin_program();
        put(alu_imm(OP_ADD, 1, 0, 7));
        put(alu_imm(OP_ADD, 2, 0, -3));
        put(alu_reg(OP_ADD, 3, 1, 2));
        put(alu_imm(OP_AND, 4, 1, -2));
        put(alu_reg(OP_AND, 5, 1, 2));
        put(not_op(6, 2));
        for (int r = 1; r <= 6; r++) begin
            put_pcrel(OP_ST, r, 'h40 + r);
        end
        end_main();
        run_program();
        wait_stores(6, "alu");
        check_store(0, 'h41, 16'd7, "ADD imm");
        check_store(1, 'h42, 16'hfffd, "ADD negative imm");
        check_store(2, 'h43, 16'd4, "ADD reg");
        check_store(3, 'h44, 16'h0006, "AND imm");
        check_store(4, 'h45, 16'h0005, "AND reg");
        check_store(5, 'h46, 16'h0002, "NOT");
    endtask

    // marker ends at 2 when taken and 3 when not
    task automatic add_branch_case(input int val, input int nzp, input int target);
        put(alu_imm(OP_AND, 5, 0, 0));
        put(alu_imm(OP_ADD, 1, 0, val));
        put(pc_rel(OP_BR, nzp, 1));
        put(alu_imm(OP_ADD, 5, 5, 1));
        put(alu_imm(OP_ADD, 5, 5, 2));
        put_pcrel(OP_ST, 5, target);
    endtask

    task automatic branch_decisions();
        int   vals [8] = '{-1, -1, 0, 0, 5, 5, -9, 0};
        int   masks [8] = '{4, 2, 2, 1, 1, 4, 3, 5};
        logic taken;
        begin_program();
        for (int i = 0; i < 8; i++) begin
            add_branch_case(vals[i], masks[i], 'h80 + i);
        end
        end_main();
        run_program();
        wait_stores(8, "branch");
        for (int i = 0; i < 8; i++) begin
            taken = ((masks[i] & 4) != 0 && vals[i] < 0) ||
                    ((masks[i] & 2) != 0 && vals[i] == 0) ||
                    ((masks[i] & 1) != 0 && vals[i] > 0);
            check_store(i, 'h80 + i, taken ? 16'd2 : 16'd3,
                        $sformatf("BR case %0d", i));
        end
    endtask

    task automatic loads_and_lea();
        begin_program();
        mem[16'h0030] = 16'hbeef;
        mem[16'h0035] = 16'h1234;
        put_pcrel(OP_LD, 1, 'h30);
        put_pcrel(OP_LEA, 2, 'h38);
        put(base_off(OP_LDR, 3, 2, -3));
        put_pcrel(OP_ST, 1, 'h50);
        put_pcrel(OP_ST, 2, 'h51);
        put_pcrel(OP_ST, 3, 'h52);
        end_main();
        run_program();
        wait_stores(3, "load");
        check_store(0, 'h50, 16'hbeef, "LD");
        check_store(1, 'h51, 16'h0038, "LEA");
        check_store(2, 'h52, 16'h1234, "LDR negative offset");
    endtask

    task automatic str_offsets();
        begin_program();
        put_pcrel(OP_LEA, 2, 'h60);
        put(alu_imm(OP_ADD, 1, 0, 9));
        put(base_off(OP_STR, 1, 2, 5));
        put(not_op(3, 1));
        put(base_off(OP_STR, 3, 2, -4));
        end_main();
        run_program();
        wait_stores(2, "str");
        check_store(0, 'h65, 16'd9, "STR positive offset");
        check_store(1, 'h5c, 16'hfff6, "STR negative offset");
    endtask

    // subroutine at 0x20 logs R7 and returns
    task automatic subroutine_calls();
        int jsr_at;
        int jsrr_at;
        begin_program();
        jsr_at = prog_addr;
        put_jsr('h20);
        put(alu_imm(OP_ADD, 1, 0, 1));
        put_pcrel(OP_ST, 1, 'h70);
        put_pcrel(OP_LEA, 4, 'h20);
        jsrr_at = prog_addr;
        put(base_off(OP_JSR, 0, 4, 0));
        put(alu_imm(OP_ADD, 1, 1, 1));
        put_pcrel(OP_ST, 1, 'h71);
        end_main();
        prog_addr = 'h20;
        put_pcrel(OP_ST, 7, 'h7f);
        put(base_off(OP_JMP, 0, 7, 0));
        run_program();
        wait_stores(4, "call");
        check_store(0, 'h7f, 16'(jsr_at + 1), "R7 after JSR");
        check_store(1, 'h70, 16'd1, "resume after JSR");
        check_store(2, 'h7f, 16'(jsrr_at + 1), "R7 after JSRR");
        check_store(3, 'h71, 16'd2, "resume after JSRR");
    endtask

    // operands start at 0xa0 and results at 0xd0 with two words per pair
    task automatic random_pairs();
        word_t a [20];
        word_t b [20];
        begin_program();
        for (int i = 0; i < 20; i++) begin
            a[i] = 16'($urandom());
            b[i] = 16'($urandom());
            mem[16'('ha0 + 2 * i)] = a[i];
            mem[16'('ha1 + 2 * i)] = b[i];
            put_pcrel(OP_LD, 1, 'ha0 + 2 * i);
            put_pcrel(OP_LD, 2, 'ha1 + 2 * i);
            put(alu_reg(OP_ADD, 3, 1, 2));
            put_pcrel(OP_ST, 3, 'hd0 + 2 * i);
            put(alu_reg(OP_AND, 4, 1, 2));
            put_pcrel(OP_ST, 4, 'hd1 + 2 * i);
        end
        end_main();
        run_program();
        wait_stores(40, "random");
        for (int i = 0; i < 20; i++) begin
            check_store(2 * i, 'hd0 + 2 * i,
                        16'((int'(a[i]) + int'(b[i])) % 65536),
                        $sformatf("pair %0d sum", i));
            check_store(2 * i + 1, 'hd1 + 2 * i, a[i] & b[i],
                        $sformatf("pair %0d and", i));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        errors = 0;
        prog_addr = 0;
        void'($urandom(32'hf1ff));
        alu_ops();
        branch_decisions();
        loads_and_lea();
        str_offsets();
        subroutine_calls();
        random_pairs();
        $display("checks done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: flist.f
src/lc3_pkg.sv
src/lc3_ctrl_if.sv
src/lc3_reg_if.sv
src/lc3_regfile.sv
src/lc3_control.sv
src/lc3_datapath.sv
src/lc3_core.sv
testbench/tb_lc3_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the LC-3 core testbench with Verilator and run it
# exit status is 0 only when the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --Wno-fatal -f flist.f --top-module tb_lc3_core -o sim_lc3 \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_lc3) || { echo "$sim_out"; echo "simulation exited with an error"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qx "=== PASS ===" && exit 0 || exit 1
